// File: uart_frame_pkg.sv
// frame layout and FSM encodings of the serial line side
package uart_frame_pkg;

    // one data byte as it travels on the wire
    typedef logic [7:0] byte_t;

    // position of a data bit inside a frame
    typedef logic [2:0] bit_idx_t;

    localparam int unsigned DATA_BITS = 8;  // 8 data bits and no parity

    // receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,  // waiting for falling edge on a high line
        RX_START = 2'd1,  // confirm start bit at half bit time
        RX_DATA  = 2'd2,  // sample data bits lsb first
        RX_STOP  = 2'd3   // sample stop bit and report frame
    } rx_state_e;

    // transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,  // txd held high
        TX_START = 2'd1,  // driving start bit (low)
        TX_DATA  = 2'd2,  // shifting out data bits
        TX_STOP  = 2'd3   // one or two high stop bits
    } tx_state_e;

endpackage

// File: uart_link_pkg.sv
// what the receiver hands to the echo queue on the parallel side
package uart_link_pkg;

    // received byte plus its framing status in 9 bits
    typedef struct packed {
        uart_frame_pkg::byte_t data;       // payload with lsb received first
        logic                  frame_err;  // stop bit was sampled low
    } rx_word_t;

endpackage

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int unsigned CLK_FREQ_HZ = 10_000_000,
    parameter int unsigned BAUD        = 625_000
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    rxd_i,       // asynchronous serial line
    output logic                    rx_valid_o,  // one-cycle pulse per frame
    output uart_link_pkg::rx_word_t rx_word_o    // byte and stop-bit status
);

    localparam int unsigned CLKS_PER_BIT = CLK_FREQ_HZ / BAUD;
    localparam int unsigned HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int unsigned CNT_W        = $clog2(CLKS_PER_BIT);

    typedef logic [CNT_W-1:0] bit_cnt_t;  // clocks within one bit time

    // two-flop synchronizer
    logic rxd_meta;
    logic rxd_sync;

    uart_frame_pkg::rx_state_e state;
    bit_cnt_t                  cnt;       // bit-time counter
    uart_frame_pkg::bit_idx_t  idx;       // data bit index
    uart_frame_pkg::byte_t     shreg;     // data shift register
    logic                      armed;     // line seen high since last frame

    logic half_tick;  // middle of start bit
    logic bit_tick;   // one full bit time elapsed

    assign half_tick = (cnt == bit_cnt_t'(HALF_BIT - 1));
    assign bit_tick  = (cnt == bit_cnt_t'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxd_meta   <= 1'b1;  // idle line level
            rxd_sync   <= 1'b1;
            state      <= uart_frame_pkg::RX_IDLE;
            cnt        <= '0;
            idx        <= '0;
            armed      <= 1'b0;
            rx_valid_o <= 1'b0;
        end else begin
            rxd_meta   <= rxd_i;
            rxd_sync   <= rxd_meta;
            rx_valid_o <= 1'b0;  // pulse lasts one cycle
            case (state)
                uart_frame_pkg::RX_IDLE: begin
                    cnt   <= '0;
                    armed <= armed | rxd_sync;  // needs a high line first
                    if (armed && !rxd_sync) begin
                        state <= uart_frame_pkg::RX_START;  // falling edge
                    end
                end
                uart_frame_pkg::RX_START: begin
                    if (half_tick) begin
                        cnt <= '0;
                        if (!rxd_sync) begin  // still low at mid start bit
                            state <= uart_frame_pkg::RX_DATA;
                            idx   <= '0;
                        end else begin
                            state <= uart_frame_pkg::RX_IDLE;  // glitch on the line
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                uart_frame_pkg::RX_DATA: begin
                    if (bit_tick) begin
                        cnt <= '0;
                        if (idx == uart_frame_pkg::bit_idx_t'(uart_frame_pkg::DATA_BITS - 1)) begin
                            state <= uart_frame_pkg::RX_STOP;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                uart_frame_pkg::RX_STOP: begin
                    if (bit_tick) begin  // mid stop bit
                        cnt        <= '0;
                        rx_valid_o <= 1'b1;
                        armed      <= rxd_sync;  // low stop bit waits for a high line
                        state      <= uart_frame_pkg::RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // payload path registers
    always_ff @(posedge clk_i) begin
        if (state == uart_frame_pkg::RX_DATA && bit_tick) begin
            shreg <= {rxd_sync, shreg[7:1]};  // lsb arrives first
        end
        if (state == uart_frame_pkg::RX_STOP && bit_tick) begin
            rx_word_o.data      <= shreg;
            rx_word_o.frame_err <= ~rxd_sync;  // stop bit must be high
        end
    end

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int unsigned CLK_FREQ_HZ = 10_000_000,
    parameter int unsigned BAUD        = 625_000,
    parameter int unsigned STOP_BITS   = 1  // 1 or 2
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  tx_start_i,  // only honoured while idle
    input  uart_frame_pkg::byte_t tx_data_i,   // captured with start
    output logic                  tx_busy_o,
    output logic                  txd_o        // registered serial out
);

    localparam int unsigned CLKS_PER_BIT = CLK_FREQ_HZ / BAUD;
    localparam int unsigned CNT_W        = $clog2(CLKS_PER_BIT);
    localparam logic [1:0]  STOP_LAST    = 2'(STOP_BITS - 1);

    typedef logic [CNT_W-1:0] bit_cnt_t;

    uart_frame_pkg::tx_state_e state;
    bit_cnt_t                  cnt;       // clocks within current bit
    uart_frame_pkg::bit_idx_t  idx;       // data bit on the line
    uart_frame_pkg::bit_idx_t  next_idx;
    logic [1:0]                stop_cnt;  // stop bits sent so far
    uart_frame_pkg::byte_t     data_q;    // latched byte
    logic                      bit_tick;

    assign bit_tick = (cnt == bit_cnt_t'(CLKS_PER_BIT - 1));
    assign next_idx = idx + 1'b1;

    always_ff @(posedge clk_i) begin
        if (state == uart_frame_pkg::TX_IDLE && tx_start_i) begin
            data_q <= tx_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state     <= uart_frame_pkg::TX_IDLE;
            cnt       <= '0;
            idx       <= '0;
            stop_cnt  <= '0;
            tx_busy_o <= 1'b0;
            txd_o     <= 1'b1;  // idle line
        end else begin
            case (state)
                uart_frame_pkg::TX_IDLE: begin
                    cnt <= '0;
                    if (tx_start_i) begin
                        state     <= uart_frame_pkg::TX_START;
                        txd_o     <= 1'b0;  // start bit from next cycle
                        tx_busy_o <= 1'b1;
                    end
                end
                uart_frame_pkg::TX_START: begin
                    if (bit_tick) begin
                        cnt   <= '0;
                        idx   <= '0;
                        txd_o <= data_q[0];  // lsb first
                        state <= uart_frame_pkg::TX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                uart_frame_pkg::TX_DATA: begin
                    if (bit_tick) begin
                        cnt <= '0;
                        if (idx == uart_frame_pkg::bit_idx_t'(uart_frame_pkg::DATA_BITS - 1)) begin
                            txd_o    <= 1'b1;  // first stop bit
                            stop_cnt <= '0;
                            state    <= uart_frame_pkg::TX_STOP;
                        end else begin
                            idx   <= next_idx;
                            txd_o <= data_q[next_idx];
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                uart_frame_pkg::TX_STOP: begin
                    if (bit_tick) begin
                        cnt <= '0;
                        if (stop_cnt == STOP_LAST) begin
                            tx_busy_o <= 1'b0;  // frame complete
                            state     <= uart_frame_pkg::TX_IDLE;
                        end else begin
                            stop_cnt <= stop_cnt + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: echo_fifo.sv
`timescale 1ns/1ps

module echo_fifo #(
    parameter int unsigned FIFO_DEPTH = 4  // power of two
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    rx_valid_i,  // can't be stalled
    input  uart_link_pkg::rx_word_t rx_word_i,
    input  logic                    tx_busy_i,
    output logic                    tx_start_o,  // one-cycle pulse that pops the head
    output uart_frame_pkg::byte_t   tx_data_o    // head entry
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;  // wraps with the depth
    typedef logic [PTR_W:0]   cnt_t;  // 0..FIFO_DEPTH

    uart_frame_pkg::byte_t mem [FIFO_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;  // occupancy
    logic full;
    logic push;
    logic pop;

    assign full = (count == cnt_t'(FIFO_DEPTH));
    // bad frames and overflow are dropped here
    assign push = rx_valid_i && !rx_word_i.frame_err && !full;
    assign pop  = tx_start_o;  // head leaves on the start edge

    assign tx_data_o = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= rx_word_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            tx_start_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // neither or both at once
            endcase
            // start when data waits and tx is idle but never back to back
            tx_start_o <= !tx_start_o && !tx_busy_i && (count != '0 || push);
        end
    end

endmodule

// File: uart_echo_top.sv
`timescale 1ns/1ps

module uart_echo_top #(
    parameter int unsigned CLK_FREQ_HZ = 10_000_000,
    parameter int unsigned BAUD        = 625_000,  // 16 clocks per bit
    parameter int unsigned STOP_BITS   = 2,        // echo slower than input
    parameter int unsigned FIFO_DEPTH  = 4
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic rxd_i,  // serial in
    output logic txd_o   // serial echo out
);

    logic                    rx_valid;
    uart_link_pkg::rx_word_t rx_word;
    logic                    tx_start;
    uart_frame_pkg::byte_t   tx_data;
    logic                    tx_busy;

    // deserializer and sole judge of framing
    uart_rx #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD        (BAUD)
    ) u_rx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rxd_i      (rxd_i),
        .rx_valid_o (rx_valid),
        .rx_word_o  (rx_word)
    );

    // holds bytes while tx is busy
    echo_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_echo_fifo (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rx_valid_i (rx_valid),
        .rx_word_i  (rx_word),
        .tx_busy_i  (tx_busy),
        .tx_start_o (tx_start),
        .tx_data_o  (tx_data)
    );

    // serializer
    uart_tx #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD        (BAUD),
        .STOP_BITS   (STOP_BITS)
    ) u_tx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .tx_start_i (tx_start),
        .tx_data_i  (tx_data),
        .tx_busy_o  (tx_busy),
        .txd_o      (txd_o)
    );

endmodule

// File: uart_echo_assertions.sv
`timescale 1ns/1ps

module uart_echo_assertions (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    rx_valid_i,
    input uart_link_pkg::rx_word_t rx_word_i,
    input logic                    tx_busy_i,
    input logic                    tx_start_i,  // queue's start pulse to tx
    input logic                    empty_i      // queue holds no entry
);

    int unsigned fail_count = 0;  // failed assertions so far

    logic good_push_idle;  // good word lands in empty queue while tx idle

    assign good_push_idle = rx_valid_i && !rx_word_i.frame_err && empty_i && !tx_busy_i;

    // tx only honours start while idle
    start_only_when_idle: assert property (
        @(posedge clk_i) disable iff (rst_i)
        tx_start_i |-> !tx_busy_i
    ) else begin
        fail_count++;
        $error("tx start raised while the transmitter was busy");
    end

    // exactly one cycle per popped entry
    start_single_cycle: assert property (
        @(posedge clk_i) disable iff (rst_i)
        tx_start_i |=> !tx_start_i
    ) else begin
        fail_count++;
        $error("tx start stayed high for two cycles in a row");
    end

    // shortest path from push to start is one cycle
    start_after_push: assert property (
        @(posedge clk_i) disable iff (rst_i)
        good_push_idle |=> tx_start_i
    ) else begin
        fail_count++;
        $error("no tx start one cycle after a push into an empty queue");
    end

endmodule

// File: tb_uart_echo.sv
`timescale 1ns/1ps

module tb_uart_echo;

    localparam int unsigned CLKS_PER_BIT = 16;  // 10 MHz at 625k baud
    localparam int unsigned ECHO_BITS    = 11;  // start, 8 data, 2 stop
    localparam int unsigned FIFO_DEPTH   = 4;
    localparam int unsigned RESET_CYCLES = 4;
    // two extra cycles between back to back echoes as busy falls and tx restarts
    localparam int unsigned ECHO_CYCLES  = ECHO_BITS * CLKS_PER_BIT + 2;
    localparam int unsigned NUM_FRAMES   = 1 + 16 + 2 + 20;  // all frames on rxd
    localparam int unsigned TIMEOUT_CYCLES =
        RESET_CYCLES + NUM_FRAMES * ECHO_BITS * CLKS_PER_BIT * 6 / 5;  // +20 %

    logic clk = 1'b0;
    logic rst;
    logic rxd;
    logic txd;

    logic [7:0]      exp_q[$];      // bytes due back on txd in order
    longint unsigned pop_times[$];  // predicted pop cycle per accepted byte
    longint unsigned cycle = 0;
    int              seed = 53;
    int unsigned     errors = 0;
    int unsigned     echoes = 0;
    int unsigned     drops = 0;     // overflow predicted by the model

    uart_echo_top u_uart_echo_top (
        .clk_i (clk),
        .rst_i (rst),
        .rxd_i (rxd),
        .txd_o (txd)
    );

    bind echo_fifo uart_echo_assertions u_fifo_checks (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rx_valid_i (rx_valid_i),
        .rx_word_i  (rx_word_i),
        .tx_busy_i  (tx_busy_i),
        .tx_start_i (tx_start_o),
        .empty_i    (count == '0)
    );

    always #50 clk = ~clk;  // 100 ns period

    always @(posedge clk) cycle <= cycle + 1;

    // occupancy model with all times taken relative to frame start
    function automatic bit predict_accept(input longint unsigned arrival);
        int unsigned     occ;
        longint unsigned pop;
        occ = 0;
        foreach (pop_times[i]) begin
            if (pop_times[i] >= arrival) begin
                occ++;  // not yet popped at this push edge
            end
        end
        if (occ >= FIFO_DEPTH) begin
            return 1'b0;  // queue full so the frame is dropped
        end
        pop = arrival + 1;  // earliest start after a push
        if (pop_times.size() != 0 && pop_times[$] + ECHO_CYCLES > pop) begin
            pop = pop_times[$] + ECHO_CYCLES;  // waits for previous echo
        end
        pop_times.push_back(pop);
        return 1'b1;
    endfunction

    task automatic drive_bit(input logic val);
        @(posedge clk);
        #1 rxd = val;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    // start, 8 data lsb first, stop, then gap_bits of idle line
    task automatic send_frame(input logic [7:0] data, input logic stop_bit,
                              input int unsigned gap_bits);
        @(posedge clk);
        #1 rxd = 1'b0;  // start bit
        if (stop_bit) begin
            if (predict_accept(cycle)) begin
                exp_q.push_back(data);
            end else begin
                drops++;
            end
        end
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(stop_bit);
        repeat (gap_bits) begin
            drive_bit(1'b1);
        end
    endtask

    task automatic check_idle(input int unsigned cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (txd === 1'b1) else begin
                $display("FAILED txd_o expected 1 actual %h", txd);
                errors++;
            end
        end
    endtask

    // wait a bounded time until every expected echo is seen
    task automatic wait_drain();
        int unsigned waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < (FIFO_DEPTH + 2) * ECHO_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected echoes never came back on txd_o", exp_q.size());
            errors += exp_q.size();
            exp_q.delete();
        end
        repeat (CLKS_PER_BIT) @(posedge clk);  // rest of last stop bit
    endtask

    initial begin : echo_monitor
        logic [7:0] got;
        logic [7:0] want;
        @(negedge rst);
        forever begin
            @(negedge txd);  // start edge just after a rising clock
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            assert (txd === 1'b0) else begin
                $display("FAILED txd_o start bit expected 0 actual %h", txd);
                errors++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                got[i] = txd;  // mid-bit sample lsb first
            end
            for (int s = 0; s < 2; s++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                assert (txd === 1'b1) else begin
                    $display("FAILED txd_o stop bit expected 1 actual %h", txd);
                    errors++;
                end
            end
            echoes++;
            if (exp_q.size() == 0) begin
                $display("an echo came back on txd_o with no byte expected");
                errors++;
            end else begin
                want = exp_q.pop_front();
                assert (got === want) else begin
                    $display("FAILED tx_data expected %h actual %h", want, got);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        logic [7:0]  data;
        int unsigned total;
        rst = 1'b1;
        rxd = 1'b1;  // idle line
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;

        check_idle(4 * CLKS_PER_BIT);  // nothing sent yet

        send_frame(8'hA5, 1'b1, 1);  // single byte
        wait_drain();

        for (int n = 0; n < 16; n++) begin
            data = 8'($random(seed));
            send_frame(data, 1'b1, 1);  // one bit time gap
        end
        wait_drain();

        send_frame(8'h3C, 1'b0, 2);  // low stop bit gives no echo
        send_frame(8'hC3, 1'b1, 1);
        wait_drain();

        for (int n = 0; n < 20; n++) begin
            data = 8'($random(seed));
            send_frame(data, 1'b1, 0);  // back to back
        end
        wait_drain();

        total = errors + u_uart_echo_top.u_echo_fifo.u_fifo_checks.fail_count;
        $display("echoes %0d, predicted drops %0d, tb errors %0d, assertion errors %0d",
                 echoes, drops, errors, u_uart_echo_top.u_echo_fifo.u_fifo_checks.fail_count);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
uart_frame_pkg.sv
uart_link_pkg.sv
uart_rx.sv
uart_tx.sv
echo_fifo.sv
uart_echo_top.sv
uart_echo_assertions.sv
tb_uart_echo.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_uart_echo
RTL_TOP    := uart_echo_top
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert
RUN_ARGS   := +verilator+error+limit+100
FAIL_MSG   := Test failed
PASS_MSG   := Test passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
